// File: logic/tack_cfg.svh
////////////////////////////////////////
// Transfer acknowledge timing constants
// Wait lengths in CLK40 cycles
////////////////////////////////////////

`ifndef TACK_CFG_SVH
`define TACK_CFG_SVH

// ROM wait after start strobe, per jumper code
`define ROM_WAIT_0 1
`define ROM_WAIT_1 2
`define ROM_WAIT_2 4
`define ROM_WAIT_3 6

// RTC cycles are slow, about 2us
`define RTC_WAIT 80

// Unclaimed cycle timeout, about 3us
`define TIMEOUT_WAIT 125

// Autovector acks as fast as possible
`define IRQ_WAIT 1

`endif

// File: logic/tackPkg.sv
////////////////////////////////////////
// Shared types for the transfer ack unit
// Jumper codes, counters, driver phases
////////////////////////////////////////

package tackPkg;

    // ROM delay jumper code
    // Names give the approximate access time
    typedef enum logic [1:0] {
        romDelay75ns  = 2'd0,
        romDelay100ns = 2'd1,
        romDelay150ns = 2'd2,
        romDelay200ns = 2'd3
    } romDelay_e;

    // RTC wait counter, 80 fits in 7 bits
    typedef logic [6:0] rtcCount_t;

    // Timeout counter, 125 fits in 7 bits
    typedef logic [6:0] timeoutCount_t;

    // TACK driver sequence
    // Idle, drive low one clock, drive high one clock
    typedef enum logic [1:0] {
        tackIdle    = 2'd0,
        tackAssert  = 2'd1,
        tackRelease = 2'd2
    } tackPhase_e;

endpackage

// File: logic/tackIfs.sv
////////////////////////////////////////
// Internal buses of the transfer ack unit
// Cycle start info and termination requests
////////////////////////////////////////

`timescale 1ns/1ps

// Registered CPU strobe, selects and CIA status
interface cycleStartIf;
    // One clock pulse per TS
    logic tsStrobe;
    // Address space selects, active high
    logic romSel;
    logic rtcSel;
    logic autovector;
    logic agnusSel;
    // Synchronized CIA status
    logic ciaEnabled;
    logic ciaFall;
    // Registered external ack
    logic extAck;

    modport source (
        output tsStrobe, romSel, rtcSel, autovector, agnusSel,
        output ciaEnabled, ciaFall, extAck
    );

    modport sink (
        input tsStrobe, romSel, rtcSel, autovector, agnusSel,
        input ciaEnabled, ciaFall, extAck
    );
endinterface

// One clock termination requests, one per source
interface termReqIf;
    logic romReq;
    logic rtcReq;
    logic irqReq;
    logic ciaReq;
    logic timeoutReq;
    logic extReq;

    modport source (output romReq, rtcReq, irqReq, ciaReq, timeoutReq, extReq);

    modport sink (input romReq, rtcReq, irqReq, ciaReq, timeoutReq, extReq);
endinterface

// File: logic/busFrontEnd.sv
////////////////////////////////////////
// Bus front end
// Registers TS and selects, syncs the CIA
// clock and enable, registers external ack
////////////////////////////////////////

`timescale 1ns/1ps

module busFrontEnd (
    input  logic CLK40,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic romSelN,
    input  logic rtcSelN,
    input  logic autovector,
    input  logic agnusSpace,
    input  logic ciaEnable,
    input  logic ciaClk,
    input  logic extAck,
    cycleStartIf.source start
);

    // Two stage synchronizers, index 1 is the safe one
    logic [1:0] ciaClkSync;
    logic [1:0] ciaEnSync;
    // Previous synchronized CIA clock
    logic ciaClkLast;

    ////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////

    // Strobe and selects land in the same clock
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            start.tsStrobe   <= 1'b0;
            start.romSel     <= 1'b0;
            start.rtcSel     <= 1'b0;
            start.autovector <= 1'b0;
            start.agnusSel   <= 1'b0;
            start.extAck     <= 1'b0;
        end else begin
            start.tsStrobe   <= ~tsN;
            start.romSel     <= ~romSelN;
            start.rtcSel     <= ~rtcSelN;
            start.autovector <= autovector;
            // Tracks the pin, timeout clears while high
            start.agnusSel   <= agnusSpace;
            start.extAck     <= extAck;
        end
    end

    ////////////////////////////////////////
    // CIA side
    ////////////////////////////////////////

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaClkSync    <= 2'b00;
            ciaEnSync     <= 2'b00;
            ciaClkLast    <= 1'b0;
            start.ciaFall <= 1'b0;
        end else begin
            ciaClkSync <= {ciaClkSync[0], ciaClk};
            ciaEnSync  <= {ciaEnSync[0], ciaEnable};
            ciaClkLast <= ciaClkSync[1];
            // High to low on the synced clock
            start.ciaFall <= ciaClkLast & ~ciaClkSync[1];
        end
    end

    assign start.ciaEnabled = ciaEnSync[1];

endmodule

// File: logic/waitTimer.sv
////////////////////////////////////////
// Wait timer
// Counts from a start pulse up to LIMIT,
// then pulses done for one clock
////////////////////////////////////////

`timescale 1ns/1ps

module waitTimer #(
    parameter type countT = logic [6:0],
    parameter int  LIMIT  = 1
) (
    input  logic CLK40,
    input  logic DELAYED_TACK_RST,
    input  logic start,
    input  logic clear,
    output logic done
);

    countT count;
    logic  busy;

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            count <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else if (clear) begin
            // Cancel wins over a new start
            count <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                if (count == countT'(LIMIT)) begin
                    // Limit reached, one pulse then idle
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    count <= '0;
                end else begin
                    count <= count + countT'(1);
                end
            end else if (start) begin
                // Start edge already counts as one
                count <= countT'(1);
                busy  <= 1'b1;
            end
        end
    end

endmodule

// File: logic/cycleTerminator.sv
////////////////////////////////////////
// Cycle terminator
// Per address space wait timing, issues
// one clock termination requests
////////////////////////////////////////

`timescale 1ns/1ps
`include "tack_cfg.svh"

module cycleTerminator (
    input  logic CLK40,
    input  logic DELAYED_TACK_RST,
    input  tackPkg::romDelay_e romDelay,
    input  logic tackActive,
    cycleStartIf.sink start,
    termReqIf.source req
);

    // CIA sequencer states, local to this block
    typedef enum logic [1:0] {
        ciaIdle  = 2'd0,
        ciaArmed = 2'd1,
        ciaHold  = 2'd2
    } ciaState_e;

    logic [2:0] romLimit;
    logic [2:0] romCount;
    logic       romBusy;
    logic [`IRQ_WAIT-1:0] irqStage;
    ciaState_e  ciaState;
    logic       extAckLast;
    logic       rtcDone;
    logic       timeoutDone;

    ////////////////////////////////////////
    // ROM cycle
    ////////////////////////////////////////

    // Jumper selects the ROM access time
    always_comb begin
        case (romDelay)
            tackPkg::romDelay75ns:  romLimit = 3'(`ROM_WAIT_0);
            tackPkg::romDelay100ns: romLimit = 3'(`ROM_WAIT_1);
            tackPkg::romDelay150ns: romLimit = 3'(`ROM_WAIT_2);
            default:                romLimit = 3'(`ROM_WAIT_3);
        endcase
    end

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            romCount   <= 3'd0;
            romBusy    <= 1'b0;
            req.romReq <= 1'b0;
        end else begin
            req.romReq <= 1'b0;
            if (romBusy) begin
                if (romCount == romLimit) begin
                    req.romReq <= 1'b1;
                    romBusy    <= 1'b0;
                    romCount   <= 3'd0;
                end else begin
                    romCount <= romCount + 3'd1;
                end
            end else if (start.tsStrobe && start.romSel) begin
                // Strobe clock counts as the first
                romCount <= 3'd1;
                romBusy  <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // IRQ acknowledge
    ////////////////////////////////////////

    // All interrupts are autovectored
    // Short delay line, no data moves
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            irqStage   <= '0;
            req.irqReq <= 1'b0;
        end else begin
            irqStage   <= (irqStage << 1) | `IRQ_WAIT'(start.tsStrobe & start.autovector);
            req.irqReq <= irqStage[`IRQ_WAIT-1];
        end
    end

    ////////////////////////////////////////
    // CIA cycle
    ////////////////////////////////////////

    // Ack on the CIA clock falling edge
    // One ack per enable period
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState   <= ciaIdle;
            req.ciaReq <= 1'b0;
        end else begin
            req.ciaReq <= 1'b0;
            case (ciaState)
                ciaIdle: begin
                    if (start.ciaEnabled) begin
                        ciaState <= ciaArmed;
                    end
                end
                ciaArmed: begin
                    if (!start.ciaEnabled) begin
                        // Enable went away before the edge
                        ciaState <= ciaIdle;
                    end else if (start.ciaFall) begin
                        req.ciaReq <= 1'b1;
                        ciaState   <= ciaHold;
                    end
                end
                ciaHold: begin
                    // Wait for enable to drop
                    if (!start.ciaEnabled) begin
                        ciaState <= ciaIdle;
                    end
                end
                default: ciaState <= ciaIdle;
            endcase
        end
    end

    ////////////////////////////////////////
    // RTC and timeout waits
    ////////////////////////////////////////

    // Any ack on the bus cancels the RTC wait
    waitTimer #(
        .countT (tackPkg::rtcCount_t),
        .LIMIT  (`RTC_WAIT)
    ) rtcWait (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .start            (start.tsStrobe & start.rtcSel),
        .clear            (tackActive),
        .done             (rtcDone)
    );

    // Every cycle starts the timeout
    // Agnus space is ended elsewhere, keep clear
    waitTimer #(
        .countT (tackPkg::timeoutCount_t),
        .LIMIT  (`TIMEOUT_WAIT)
    ) timeoutWait (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .start            (start.tsStrobe),
        .clear            (tackActive | start.agnusSel),
        .done             (timeoutDone)
    );

    assign req.rtcReq     = rtcDone;
    assign req.timeoutReq = timeoutDone;

    ////////////////////////////////////////
    // External acknowledge
    ////////////////////////////////////////

    // Rising edge only, one request per ack
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            extAckLast <= 1'b0;
            req.extReq <= 1'b0;
        end else begin
            extAckLast <= start.extAck;
            req.extReq <= start.extAck & ~extAckLast;
        end
    end

endmodule

// File: logic/tackDriver.sv
////////////////////////////////////////
// TACK driver
// Low pulse, high release, then let go
// TBI follows TACK, TCI stays high for ROM
////////////////////////////////////////

`timescale 1ns/1ps

module tackDriver (
    input  logic CLK40,
    input  logic DELAYED_TACK_RST,
    termReqIf.sink req,
    output logic tackN,
    output logic tbiN,
    output logic tciN,
    output logic tackOe,
    output logic tackActive
);

    tackPkg::tackPhase_e phase;
    // Current cycle is a ROM cycle
    logic romCycle;
    logic anyReq;

    assign anyReq = req.romReq | req.rtcReq | req.irqReq |
                    req.ciaReq | req.timeoutReq | req.extReq;

    // Requests outside idle are dropped
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            phase    <= tackPkg::tackIdle;
            romCycle <= 1'b0;
        end else begin
            case (phase)
                tackPkg::tackIdle: begin
                    if (anyReq) begin
                        phase    <= tackPkg::tackAssert;
                        romCycle <= req.romReq;
                    end
                end
                tackPkg::tackAssert: phase <= tackPkg::tackRelease;
                tackPkg::tackRelease: phase <= tackPkg::tackIdle;
                default: phase <= tackPkg::tackIdle;
            endcase
        end
    end

    // Outputs decoded from the phase
    assign tackN      = (phase != tackPkg::tackAssert);
    // No bursts, always inhibit
    assign tbiN       = tackN;
    // ROM data is cacheable
    assign tciN       = tackN | romCycle;
    assign tackOe     = (phase != tackPkg::tackIdle);
    assign tackActive = tackOe;

endmodule

// File: logic/transferAck.sv
////////////////////////////////////////
// Transfer acknowledge unit, top level
// 68040 bus cycle termination
////////////////////////////////////////

`timescale 1ns/1ps

module transferAck (
    input  logic       CLK40,
    input  logic       DELAYED_TACK_RST,
    input  logic       tsN,
    input  logic       romSelN,
    input  logic       rtcSelN,
    input  logic       autovector,
    input  logic       agnusSpace,
    input  logic       ciaEnable,
    input  logic       ciaClk,
    input  logic       extAck,
    input  logic [1:0] romDelay,
    output logic       tackN,
    output logic       tbiN,
    output logic       tciN,
    output logic       tackOe
);

    // Front end to terminator
    cycleStartIf startBus ();
    // Terminator to driver
    termReqIf reqBus ();
    // Ack in progress, cancels pending waits
    logic tackActive;

    busFrontEnd frontEnd (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .romSelN          (romSelN),
        .rtcSelN          (rtcSelN),
        .autovector       (autovector),
        .agnusSpace       (agnusSpace),
        .ciaEnable        (ciaEnable),
        .ciaClk           (ciaClk),
        .extAck           (extAck),
        .start            (startBus.source)
    );

    cycleTerminator terminator (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .romDelay         (tackPkg::romDelay_e'(romDelay)),
        .tackActive       (tackActive),
        .start            (startBus.sink),
        .req              (reqBus.source)
    );

    tackDriver driver (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .req              (reqBus.sink),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tciN             (tciN),
        .tackOe           (tackOe),
        .tackActive       (tackActive)
    );

endmodule

// File: bench/clockGen.sv
////////////////////////////////////////
// Testbench clock and reset
// 4 ns clock, reset held 16 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module clockGen (
    output logic CLK40,
    output logic DELAYED_TACK_RST
);

    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;
    end

    // Release on a rising edge after 16 cycles
    initial begin
        DELAYED_TACK_RST <= 1'b1;
        repeat (16) @(posedge CLK40);
        DELAYED_TACK_RST <= 1'b0;
    end

endmodule

// File: bench/tack_chk.sv
////////////////////////////////////////
// TACK driver checker
// Pulse shape and phase order assertions
////////////////////////////////////////

`timescale 1ns/1ps

module tackChk (
    input logic CLK40,
    input logic DELAYED_TACK_RST,
    input logic tackN,
    input logic tbiN,
    input logic tackOe,
    input tackPkg::tackPhase_e phase
);

    // TACK low for a single clock only
    tackOneClock: assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        !tackN |=> tackN)
        else $error("tackN low for more than one clock");

    // Output enable covers the low clock
    oeDuringLow: assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        !tackN |-> tackOe)
        else $error("tackOe low while tackN is low");

    // And the driven-high clock after it
    oeAfterLow: assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        !tackN |=> tackOe)
        else $error("tackOe dropped right after tackN low");

    // No burst accepted, TBI tracks TACK
    tbiFollows: assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        tackOe |-> (tbiN == tackN))
        else $error("tbiN differs from tackN while driven");

    // Assert phase always hands over to release
    assertThenRelease: assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        (phase == tackPkg::tackAssert) |=> (phase == tackPkg::tackRelease))
        else $error("assert phase not followed by release");

endmodule

// File: bench/transferAckTb.sv
////////////////////////////////////////
// Transfer ack testbench
// Golden file scenarios, latency and
// TCI/TBI checks against expected values
////////////////////////////////////////

`timescale 1ns/1ps

module transferAckTb;

    // Scenario kinds as coded in the golden file
    localparam int kindIrq     = 1;
    localparam int kindRom     = 2;
    localparam int kindRtc     = 3;
    localparam int kindTimeout = 4;
    localparam int kindAgnus   = 5;
    localparam int kindCia     = 6;
    localparam int kindExt     = 7;

    logic       CLK40;
    logic       DELAYED_TACK_RST;
    logic       tsN;
    logic       romSelN;
    logic       rtcSelN;
    logic       autovector;
    logic       agnusSpace;
    logic       ciaEnable;
    logic       ciaClk;
    logic       extAck;
    logic [1:0] romDelay;
    logic       tackN;
    logic       tbiN;
    logic       tciN;
    logic       tackOe;

    // Four words per scenario
    logic [31:0] golden [0:63];
    logic [31:0] rng;

    clockGen clocks (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST)
    );

    transferAck UUT (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .romSelN          (romSelN),
        .rtcSelN          (rtcSelN),
        .autovector       (autovector),
        .agnusSpace       (agnusSpace),
        .ciaEnable        (ciaEnable),
        .ciaClk           (ciaClk),
        .extAck           (extAck),
        .romDelay         (romDelay),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tciN             (tciN),
        .tackOe           (tackOe)
    );

    // Pulse shape checker on the driver
    bind tackDriver tackChk driverChk (
        .CLK40            (CLK40),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tackOe           (tackOe),
        .phase            (phase)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string kindName(input int kind);
        case (kind)
            kindIrq:     return "irq";
            kindRom:     return "rom";
            kindRtc:     return "rtc";
            kindTimeout: return "timeout";
            kindAgnus:   return "agnus";
            kindCia:     return "cia";
            kindExt:     return "ext";
            default:     return "unknown";
        endcase
    endfunction

    task automatic failRun(input string message);
        $display("%s", message);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            failRun($sformatf("mismatch %s expected %0d actual %0d",
                              testName, expected, actual));
        end
    endtask

    // Bus idle, nothing driven
    task automatic quietClocks(input string name, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            @(negedge CLK40);
            checkEqual({name, " idle tackOe"}, 0, int'(tackOe));
            checkEqual({name, " idle tackN"}, 1, int'(tackN));
            checkEqual({name, " idle tbiN"}, 1, int'(tbiN));
            checkEqual({name, " idle tciN"}, 1, int'(tciN));
        end
    endtask

    // Outputs must stay idle while in reset
    task automatic waitResetRelease();
        int k;
        bit released;
        released = 1'b0;
        for (k = 0; k < 200 && !released; k++) begin
            @(negedge CLK40);
            checkEqual("reset tackOe", 0, int'(tackOe));
            checkEqual("reset tackN", 1, int'(tackN));
            checkEqual("reset tbiN", 1, int'(tbiN));
            checkEqual("reset tciN", 1, int'(tciN));
            released = !DELAYED_TACK_RST;
        end
        if (!released) begin
            failRun("reset was not released within 200 clocks");
        end
    endtask

    // TS low for one clock, selects alongside, returns on the sampling edge
    task automatic startCycle(input int kind, input int romCode);
        @(posedge CLK40);
        tsN        <= 1'b0;
        romDelay   <= romCode[1:0];
        romSelN    <= !(kind == kindRom);
        rtcSelN    <= !(kind == kindRtc);
        autovector <= (kind == kindIrq);
        if (kind == kindAgnus) begin
            agnusSpace <= 1'b1;
        end
        @(posedge CLK40);
        tsN        <= 1'b1;
        romSelN    <= 1'b1;
        rtcSelN    <= 1'b1;
        autovector <= 1'b0;
    endtask

    // Clocks from the edge just taken until TACK low
    task automatic measureAck(input string name, output int latency,
                              output int tciSeen, output int tbiSeen);
        int k;
        bit seen;
        seen    = 1'b0;
        latency = -1;
        tciSeen = -1;
        tbiSeen = -1;
        for (k = 0; k < 200 && !seen; k++) begin
            @(negedge CLK40);
            if (!tackN) begin
                seen    = 1'b1;
                latency = k;
                tciSeen = int'(tciN);
                tbiSeen = int'(tbiN);
            end
        end
        if (!seen) begin
            failRun({"no tackN low within 200 clocks in ", name});
        end
    endtask

    // One driven-high clock, then let go
    task automatic finishAck(input string name);
        @(negedge CLK40);
        checkEqual({name, " release tackN"}, 1, int'(tackN));
        checkEqual({name, " release tackOe"}, 1, int'(tackOe));
        @(negedge CLK40);
        checkEqual({name, " after release tackOe"}, 0, int'(tackOe));
    endtask

    task automatic watchNoAck(input string name, input int count);
        int k;
        for (k = 0; k < count; k++) begin
            @(negedge CLK40);
            if (!tackN) begin
                failRun({"tackN went low where no ack was due in ", name});
            end
        end
    endtask

    ////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////

    task automatic runScenario(input int kind, input int romCode,
                               input int expLatency, input int expTci);
        string name;
        int latency;
        int tciSeen;
        int tbiSeen;
        int k;
        name = $sformatf("%s romDelay %0d", kindName(kind), romCode);
        case (kind)
            kindIrq, kindRom, kindRtc, kindTimeout: begin
                startCycle(kind, romCode);
                measureAck(name, latency, tciSeen, tbiSeen);
                checkEqual({name, " latency"}, expLatency, latency);
                checkEqual({name, " tciN"}, expTci, tciSeen);
                checkEqual({name, " tbiN"}, 0, tbiSeen);
                finishAck(name);
            end
            kindAgnus: begin
                // Timeout stays cleared while Agnus owns the cycle
                startCycle(kind, romCode);
                watchNoAck(name, 200);
                @(posedge CLK40);
                agnusSpace <= 1'b0;
            end
            kindCia: begin
                @(posedge CLK40);
                ciaClk    <= 1'b1;
                ciaEnable <= 1'b1;
                // Let enable and clock settle through the synchronizers
                quietClocks(name, 12);
                @(posedge CLK40);
                ciaClk <= 1'b0;
                // First edge that samples the low level
                @(posedge CLK40);
                measureAck(name, latency, tciSeen, tbiSeen);
                checkEqual({name, " latency"}, expLatency, latency);
                checkEqual({name, " tciN"}, expTci, tciSeen);
                checkEqual({name, " tbiN"}, 0, tbiSeen);
                finishAck(name);
                // More falling edges, same enable period
                for (k = 0; k < 60; k++) begin
                    @(posedge CLK40);
                    if (k % 10 == 2) begin
                        ciaClk <= ~ciaClk;
                    end
                    @(negedge CLK40);
                    if (!tackN) begin
                        failRun({"second CIA ack in one enable period in ", name});
                    end
                end
                @(posedge CLK40);
                ciaEnable <= 1'b0;
                // CIA clock keeps running with the enable off
                for (k = 0; k < 40; k++) begin
                    @(posedge CLK40);
                    if (k % 10 == 2) begin
                        ciaClk <= ~ciaClk;
                    end
                    @(negedge CLK40);
                    if (!tackN) begin
                        failRun({"CIA ack while the CIA enable was off in ", name});
                    end
                end
            end
            kindExt: begin
                startCycle(kind, romCode);
                quietClocks(name, 20);
                @(posedge CLK40);
                extAck <= 1'b1;
                // Edge that samples extAck high
                @(posedge CLK40);
                measureAck(name, latency, tciSeen, tbiSeen);
                checkEqual({name, " latency"}, expLatency, latency);
                checkEqual({name, " tciN"}, expTci, tciSeen);
                checkEqual({name, " tbiN"}, 0, tbiSeen);
                finishAck(name);
                @(posedge CLK40);
                extAck <= 1'b0;
                // Timeout of this cycle would land inside the window
                watchNoAck(name, 200);
            end
            default: failRun($sformatf("golden file holds unknown scenario kind %0d", kind));
        endcase
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int idx;
        int kind;
        int romCode;
        int expLatency;
        int expTci;
        int gap;
        tsN        <= 1'b1;
        romSelN    <= 1'b1;
        rtcSelN    <= 1'b1;
        autovector <= 1'b0;
        agnusSpace <= 1'b0;
        ciaEnable  <= 1'b0;
        ciaClk     <= 1'b0;
        extAck     <= 1'b0;
        romDelay   <= 2'd0;
        rng = 32'd11;
        $readmemh("bench/tack_golden.txt", golden);

        waitResetRelease();

        idx  = 0;
        kind = int'(golden[0]);
        while (kind != 0 && idx < 15) begin
            romCode    = int'(golden[idx * 4 + 1]);
            expLatency = int'(golden[idx * 4 + 2]);
            expTci     = int'(golden[idx * 4 + 3]);
            // Random idle gap, also checks the bus stays quiet
            rng = xorshift(rng);
            gap = 2 + int'(rng % 32'd6);
            quietClocks("gap", gap);
            runScenario(kind, romCode, expLatency, expTci);
            idx++;
            kind = int'(golden[idx * 4]);
        end

        if (idx == 0) begin
            failRun("golden file held no scenarios");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+logic
logic/tackPkg.sv
logic/tackIfs.sv
logic/busFrontEnd.sv
logic/waitTimer.sv
logic/cycleTerminator.sv
logic/tackDriver.sv
logic/transferAck.sv
bench/clockGen.sv
bench/tack_chk.sv
bench/transferAckTb.sv

// File: run.sh
#!/bin/sh
# Build the transfer ack testbench with Verilator and run it
# Pass or fail is taken from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f list.f \
    --top-module transferAckTb \
    -o transferAckSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

simOut=$(./obj_dir/transferAckSim)
status=$?
echo "$simOut"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if echo "$simOut" | grep -q "Test completed successfully"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

// File: bench/tack_golden.txt
// Columns: kind romDelay latency tciN, all hex, latency in clocks from the sampling edge
// Kinds: 1 irq, 2 rom, 3 rtc, 4 timeout, 5 agnus, 6 cia, 7 ext, 0 ends the list; fff is no ack
// Autovector interrupt acknowledge
1 0 003 0
// ROM cycles, one per jumper code, TCI held high
2 0 003 1
2 1 004 1
2 2 006 1
2 3 008 1
// IRQ again with another jumper, TCI follows TACK
1 2 003 0
// RTC cycle, long fixed wait
3 0 052 0
// Unclaimed cycle ends on the timeout
4 1 07f 0
// Agnus space, ended by another chip
5 0 fff 1
// CIA cycle on the CIA clock falling edge
6 0 004 0
// External acknowledge, latency from its sampling edge
7 0 002 0
// End of list
0 0 000 0
